// ==== hw/cacheGeomPkg.sv ====
package cacheGeomPkg;

  // Byte address split into tag, set index, word offset and byte offset
  localparam int addrBits = 32;
  localparam int numSets = 16;
  localparam int wordsPerBlock = 4;
  localparam int numWays = 2;

  localparam int byteOffBits = 2;
  localparam int wordOffBits = $clog2(wordsPerBlock);
  localparam int indexBits = $clog2(numSets);
  localparam int tagBits = addrBits - indexBits - wordOffBits - byteOffBits;

  typedef logic [indexBits-1:0] setIndexT;
  typedef logic [wordOffBits-1:0] wordOffT;
  typedef logic [tagBits-1:0] tagT;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    FLUSHSCAN,
    FLUSHWB
  } cacheStateE;

endpackage

// ==== hw/busPkg.sv ====
package busPkg;

  localparam int dataBits = 32;
  localparam int bytesPerWord = dataBits / 8;
  // Word address, byte lanes come from wbSel
  localparam int busAddrBits = 30;

  typedef logic [dataBits-1:0] dataWordT;
  typedef logic [bytesPerWord-1:0] byteMaskT;
  typedef logic [busAddrBits-1:0] busAddrT;

  // Kind of the current Wishbone cycle
  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } busOpE;

endpackage

// ==== hw/cacheIfs.sv ====
`timescale 1ns/1ns

// Tag, valid, dirty and LRU port between controller and tag store
interface tagPortIf;
  import cacheGeomPkg::*;

  setIndexT index;
  tagT lookupTag;
  logic writeWay;
  logic setValid;
  logic setDirty;
  logic clearDirty;
  logic invalidateAll;
  logic touchLru;

  logic hitWay1;
  logic hitWay2;
  logic victimWay;
  logic victimDirty;
  tagT victimTag;
  logic lruBit;

  modport ctrl (
    output index, lookupTag, writeWay, setValid, setDirty, clearDirty,
           invalidateAll, touchLru,
    input hitWay1, hitWay2, victimWay, victimDirty, victimTag, lruBit
  );

  modport store (
    input index, lookupTag, writeWay, setValid, setDirty, clearDirty,
          invalidateAll, touchLru,
    output hitWay1, hitWay2, victimWay, victimDirty, victimTag, lruBit
  );
endinterface

// Word port into the data array
interface dataPortIf;
  import cacheGeomPkg::*;
  import busPkg::*;

  setIndexT index;
  logic way;
  wordOffT wordOff;
  logic writeEnable;
  byteMaskT byteMask;
  dataWordT writeData;
  dataWordT readData;

  modport ctrl (
    output index, way, wordOff, writeEnable, byteMask, writeData,
    input readData
  );

  modport store (
    input index, way, wordOff, writeEnable, byteMask, writeData,
    output readData
  );
endinterface

// ==== hw/tagStore.sv ====
`timescale 1ns/1ns

module tagStore (
  input logic clk,
  input logic reset,
  tagPortIf.store tagPort
);
  import cacheGeomPkg::*;

  tagT tagArr [numWays][numSets];
  logic [numWays-1:0][numSets-1:0] validBits;
  logic [numWays-1:0][numSets-1:0] dirtyBits;
  // Per set, the way used least recently
  logic [numSets-1:0] lruBits;

  setIndexT idx;
  logic way;
  logic valid0;
  logic valid1;

  assign idx = tagPort.index;
  assign way = tagPort.writeWay;
  assign valid0 = validBits[0][idx];
  assign valid1 = validBits[1][idx];

  // Tags only change when a block is refilled
  always_ff @(posedge clk) begin
    if (tagPort.setValid) begin
      tagArr[way][idx] <= tagPort.lookupTag;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits <= '0;
    end else if (tagPort.invalidateAll) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits <= '0;
    end else begin
      // Fresh block arrives clean
      if (tagPort.setValid) begin
        validBits[way][idx] <= 1'b1;
        dirtyBits[way][idx] <= 1'b0;
      end
      if (tagPort.setDirty) begin
        dirtyBits[way][idx] <= 1'b1;
      end
      if (tagPort.clearDirty) begin
        dirtyBits[way][idx] <= 1'b0;
      end
      if (tagPort.touchLru) begin
        lruBits[idx] <= ~way;
      end
    end
  end

  // Hit detection on both ways
  assign tagPort.hitWay1 = valid0 && (tagArr[0][idx] == tagPort.lookupTag);
  assign tagPort.hitWay2 = valid1 && (tagArr[1][idx] == tagPort.lookupTag);

  // Empty way first, otherwise the older one
  always_comb begin
    if (!valid0) begin
      tagPort.victimWay = 1'b0;
    end else if (!valid1) begin
      tagPort.victimWay = 1'b1;
    end else begin
      tagPort.victimWay = lruBits[idx];
    end
  end

  // State of the way being replaced or flushed
  assign tagPort.victimDirty = validBits[way][idx] && dirtyBits[way][idx];
  assign tagPort.victimTag = tagArr[way][idx];
  assign tagPort.lruBit = lruBits[idx];

endmodule

// ==== hw/dataStore.sv ====
`timescale 1ns/1ns

module dataStore (
  input logic clk,
  dataPortIf.store dataPort
);
  import cacheGeomPkg::*;
  import busPkg::*;

  dataWordT mem [numWays][numSets][wordsPerBlock];

  dataWordT curWord;
  dataWordT mergedWord;

  assign curWord = mem[dataPort.way][dataPort.index][dataPort.wordOff];

  // Byte lanes outside the mask keep their old value
  always_comb begin
    mergedWord = curWord;
    for (int b = 0; b < bytesPerWord; b++) begin
      if (dataPort.byteMask[b]) begin
        mergedWord[b*8 +: 8] = dataPort.writeData[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dataPort.writeEnable) begin
      mem[dataPort.way][dataPort.index][dataPort.wordOff] <= mergedWord;
    end
  end

  // Combinational read of the addressed word
  assign dataPort.readData = curWord;

endmodule

// ==== hw/dcacheController.sv ====
`timescale 1ns/1ns

module dcacheController (
  input logic clk,
  input logic reset,
  input logic cpuReq,
  input logic cpuWe,
  input logic [cacheGeomPkg::addrBits-1:0] cpuAddr,
  input busPkg::dataWordT cpuWdata,
  input busPkg::byteMaskT cpuMask,
  input logic flushReq,
  output busPkg::dataWordT cpuRdata,
  output logic cpuAck,
  output logic flushDone,
  output logic wbCyc,
  output logic wbStb,
  output logic wbWe,
  output busPkg::busAddrT wbAdr,
  output busPkg::dataWordT wbDatO,
  output busPkg::byteMaskT wbSel,
  input busPkg::dataWordT wbDatI,
  input logic wbAck,
  tagPortIf.ctrl tagPort,
  dataPortIf.ctrl dataPort
);
  import cacheGeomPkg::*;
  import busPkg::*;

  cacheStateE state, nextState;
  busOpE busOp;

  tagT reqTag;
  setIndexT reqIndex;
  wordOffT reqWord;
  setIndexT curIndex;
  logic curWay;

  wordOffT beat;
  logic lastBeat;
  logic busActive;
  logic flushing;

  // Set in the upper bits, way in bit 0
  logic [indexBits:0] flushCount;
  setIndexT flushSet;
  logic flushWay;
  logic lastEntry;

  logic missWay;
  logic hit;
  logic lookupHit;
  logic storeHit;
  logic refillBeat;
  logic scanDone;

  // Request address fields
  assign reqTag = cpuAddr[addrBits-1 -: tagBits];
  assign reqIndex = cpuAddr[byteOffBits+wordOffBits +: indexBits];
  assign reqWord = cpuAddr[byteOffBits +: wordOffBits];

  assign flushSet = flushCount[indexBits:1];
  assign flushWay = flushCount[0];
  assign lastEntry = &flushCount;

  assign busActive = (state == WRITEBACK) || (state == REFILL) || (state == FLUSHWB);
  assign flushing = (state == FLUSHSCAN) || (state == FLUSHWB);
  assign lastBeat = (beat == wordOffT'(wordsPerBlock - 1));

  assign hit = tagPort.hitWay1 | tagPort.hitWay2;
  assign lookupHit = (state == LOOKUP) && cpuReq && hit;
  assign storeHit = lookupHit && cpuWe;
  assign refillBeat = (state == REFILL) && wbAck;
  // Clean entry seen during the flush walk
  assign scanDone = (state == FLUSHSCAN) && !tagPort.victimDirty;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (flushReq) begin
          nextState = FLUSHSCAN;
        end else if (cpuReq) begin
          nextState = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!cpuReq || hit) begin
          nextState = IDLE;
        end else if (tagPort.victimDirty) begin
          nextState = WRITEBACK;
        end else begin
          nextState = REFILL;
        end
      end
      WRITEBACK: begin
        if (wbAck && lastBeat) begin
          nextState = REFILL;
        end
      end
      // Re-enter lookup so the access completes as a hit
      REFILL: begin
        if (wbAck && lastBeat) begin
          nextState = LOOKUP;
        end
      end
      FLUSHSCAN: begin
        if (tagPort.victimDirty) begin
          nextState = FLUSHWB;
        end else if (lastEntry) begin
          nextState = IDLE;
        end
      end
      FLUSHWB: begin
        if (wbAck && lastBeat) begin
          nextState = FLUSHSCAN;
        end
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  // Beat counter, held while the slave stalls
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beat <= '0;
    end else if (!busActive) begin
      beat <= '0;
    end else if (wbAck) begin
      beat <= beat + 1'b1;
    end
  end

  // Walks every set and way, wraps back to zero after the last one
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      flushCount <= '0;
    end else if (scanDone) begin
      flushCount <= flushCount + 1'b1;
    end
  end

  // Way chosen for the refill stays fixed across writeback and refill
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      missWay <= 1'b0;
    end else if ((state == LOOKUP) && !hit) begin
      missWay <= tagPort.victimWay;
    end
  end

  always_comb begin
    case (state)
      LOOKUP: curWay = hit ? tagPort.hitWay2 : tagPort.victimWay;
      WRITEBACK, REFILL: curWay = missWay;
      FLUSHSCAN, FLUSHWB: curWay = flushWay;
      default: curWay = tagPort.hitWay2;
    endcase
  end

  assign curIndex = flushing ? flushSet : reqIndex;

  // Tag store controls
  assign tagPort.index = curIndex;
  assign tagPort.lookupTag = reqTag;
  assign tagPort.writeWay = curWay;
  assign tagPort.setValid = refillBeat && lastBeat;
  assign tagPort.setDirty = storeHit;
  assign tagPort.clearDirty = ((state == WRITEBACK) || (state == FLUSHWB)) && wbAck && lastBeat;
  assign tagPort.invalidateAll = scanDone && lastEntry;
  // LRU only changes when the accessed way was the older one
  assign tagPort.touchLru = lookupHit && (tagPort.lruBit == curWay);

  // Data array controls
  assign dataPort.index = curIndex;
  assign dataPort.way = curWay;
  assign dataPort.wordOff = busActive ? beat : reqWord;
  assign dataPort.writeEnable = storeHit || refillBeat;
  assign dataPort.byteMask = refillBeat ? '1 : cpuMask;
  assign dataPort.writeData = refillBeat ? wbDatI : cpuWdata;

  // CPU side
  assign cpuRdata = dataPort.readData;
  assign cpuAck = lookupHit;
  assign flushDone = scanDone && lastEntry;

  // Wishbone master
  assign busOp = (state == REFILL) ? BUS_READ : BUS_WRITE;
  assign wbCyc = busActive;
  assign wbStb = busActive;
  assign wbWe = busActive && (busOp == BUS_WRITE);
  assign wbSel = '1;
  assign wbDatO = dataPort.readData;

  always_comb begin
    if (busOp == BUS_WRITE) begin
      wbAdr = {tagPort.victimTag, curIndex, beat};
    end else begin
      wbAdr = {reqTag, reqIndex, beat};
    end
  end

endmodule

// ==== hw/dcacheTop.sv ====
`timescale 1ns/1ns

module dcacheTop (
  input logic clk,
  input logic reset,
  input logic cpuReq,
  input logic cpuWe,
  input logic [cacheGeomPkg::addrBits-1:0] cpuAddr,
  input busPkg::dataWordT cpuWdata,
  input busPkg::byteMaskT cpuMask,
  output busPkg::dataWordT cpuRdata,
  output logic cpuAck,
  input logic flushReq,
  output logic flushDone,
  output logic wbCyc,
  output logic wbStb,
  output logic wbWe,
  output busPkg::busAddrT wbAdr,
  output busPkg::dataWordT wbDatO,
  output busPkg::byteMaskT wbSel,
  input busPkg::dataWordT wbDatI,
  input logic wbAck
);

  tagPortIf tagPort ();
  dataPortIf dataPort ();

  dcacheController controller0 (
    .clk(clk),
    .reset(reset),
    .cpuReq(cpuReq),
    .cpuWe(cpuWe),
    .cpuAddr(cpuAddr),
    .cpuWdata(cpuWdata),
    .cpuMask(cpuMask),
    .flushReq(flushReq),
    .cpuRdata(cpuRdata),
    .cpuAck(cpuAck),
    .flushDone(flushDone),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbWe(wbWe),
    .wbAdr(wbAdr),
    .wbDatO(wbDatO),
    .wbSel(wbSel),
    .wbDatI(wbDatI),
    .wbAck(wbAck),
    .tagPort(tagPort.ctrl),
    .dataPort(dataPort.ctrl)
  );

  tagStore tags0 (
    .clk(clk),
    .reset(reset),
    .tagPort(tagPort.store)
  );

  dataStore data0 (
    .clk(clk),
    .dataPort(dataPort.store)
  );

endmodule

// ==== tests/dcacheAsserts.sv ====
`timescale 1ns/1ns

module dcacheAsserts (
  input logic clk,
  input logic reset,
  input cacheGeomPkg::cacheStateE state,
  input logic cpuAck,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck,
  input busPkg::busAddrT wbAdr,
  input busPkg::dataWordT wbDatO
);
  import cacheGeomPkg::*;

  // Number of assertion failures so far
  int failCount = 0;

  stbNeedsCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
    else begin
      $error("wbStb high without wbCyc");
      failCount++;
    end

  // A stalled beat keeps address and write data
  beatHeld: assert property (@(posedge clk) disable iff (reset)
      (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbDatO)))
    else begin
      $error("Wishbone beat changed before wbAck");
      failCount++;
    end

  ackPulse: assert property (@(posedge clk) disable iff (reset) cpuAck |=> !cpuAck)
    else begin
      $error("cpuAck high on two consecutive cycles");
      failCount++;
    end

  // The lookup right after a refill finds the new block
  refillHits: assert property (@(posedge clk) disable iff (reset)
      ((state == LOOKUP) && ($past(state) == REFILL)) |-> cpuAck)
    else begin
      $error("lookup after refill did not hit");
      failCount++;
    end

endmodule

bind dcacheController dcacheAsserts asserts0 (
  .clk(clk),
  .reset(reset),
  .state(state),
  .cpuAck(cpuAck),
  .wbCyc(wbCyc),
  .wbStb(wbStb),
  .wbAck(wbAck),
  .wbAdr(wbAdr),
  .wbDatO(wbDatO)
);

// ==== tests/dcacheTb.sv ====
`timescale 1ns/1ns

module dcacheTb;
  import cacheGeomPkg::*;
  import busPkg::*;

  localparam int resetCycles = 16;
  localparam int memWords = 256;
  localparam int maxOps = 300;
  localparam int cyclesPerOp = 40;
  // Every entry dirty, each beat at the longest ack delay
  localparam int flushCycles = numSets * numWays * (wordsPerBlock * 4 + 2);
  localparam int timeoutCycles = resetCycles + maxOps * cyclesPerOp + flushCycles;
  localparam logic [15:0] lfsrSeed = 16'd57101;

  logic clk = 1'b0;
  logic reset;
  logic cpuReq;
  logic cpuWe;
  logic [addrBits-1:0] cpuAddr;
  dataWordT cpuWdata;
  byteMaskT cpuMask;
  dataWordT cpuRdata;
  logic cpuAck;
  logic flushReq;
  logic flushDone;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  busAddrT wbAdr;
  dataWordT wbDatO;
  byteMaskT wbSel;
  dataWordT wbDatI;
  logic wbAck;

  dataWordT memModel [memWords];
  dataWordT shadow [memWords];
  logic [15:0] stimLfsr = lfsrSeed;
  logic [15:0] busLfsr = lfsrSeed;
  int beatWait = -1;
  int cycleCount = 0;
  logic expectRead = 1'b0;
  dataWordT expectData = '0;
  // Request issued and not yet acknowledged
  logic reqPending = 1'b0;

  dcacheTop dut0 (.*);

  always #50 clk = ~clk;

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int stimBits(input int n);
    int v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | stimLfsr[0];
      stimLfsr = lfsrStep(stimLfsr);
    end
    return v;
  endfunction

  // Bus delays use their own stream
  function automatic int busBits(input int n);
    int v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | busLfsr[0];
      busLfsr = lfsrStep(busLfsr);
    end
    return v;
  endfunction

  // Masked store applied to one memory word
  function automatic dataWordT expectedWord(input dataWordT oldWord, input dataWordT wdata,
                                            input byteMaskT mask);
    dataWordT laneMask;
    laneMask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (oldWord & ~laneMask) | (wdata & laneMask);
  endfunction

  task automatic reportFailure(input string why);
    $display("Checks failed");
    $fatal(1, "%s", why);
  endtask

  task automatic checkData(input string name, input dataWordT got, input dataWordT exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      reportFailure("a data word did not match");
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      reportFailure("a single-bit result did not match");
    end
  endtask

  // One Wishbone beat against the memory model
  task automatic serveBeat();
    int idx;
    if (wbAdr >= busAddrT'(memWords)) begin
      reportFailure("Wishbone address outside the memory model");
    end
    idx = int'(wbAdr);
    if (wbWe) begin
      for (int b = 0; b < 4; b++) begin
        if (wbSel[b]) begin
          memModel[idx][b*8 +: 8] = wbDatO[b*8 +: 8];
        end
      end
    end else begin
      wbDatI = memModel[idx];
    end
  endtask

  // Slave with 0 to 3 wait cycles per beat
  always @(negedge clk) begin
    if (wbAck) begin
      wbAck = 1'b0;
      beatWait = -1;
    end
    if (!reset && wbCyc && wbStb) begin
      if (beatWait < 0) begin
        beatWait = busBits(2);
      end
      if (beatWait == 0) begin
        serveBeat();
        wbAck = 1'b1;
      end else begin
        beatWait = beatWait - 1;
      end
    end
  end

  // Checks every CPU acknowledge
  always @(posedge clk) begin
    if (!reset) begin
      if (cpuAck) begin
        checkFlag("cpuAck", cpuAck, reqPending);
        if (expectRead) begin
          checkData("cpuRdata", cpuRdata, expectData);
        end
        reqPending = 1'b0;
      end
      if (dut0.controller0.asserts0.failCount != 0) begin
        reportFailure("a bus or CPU handshake assertion failed");
      end
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutCycles) begin
      reportFailure("test did not finish within the cycle limit");
    end
  end

  task automatic cpuAccess(input logic write, input int word, input dataWordT data,
                           input byteMaskT mask);
    if (write) begin
      shadow[word] = expectedWord(shadow[word], data, mask);
    end
    expectRead = !write;
    expectData = shadow[word];
    reqPending = 1'b1;
    cpuReq = 1'b1;
    cpuWe = write;
    cpuAddr = word << 2;
    cpuWdata = data;
    cpuMask = mask;
    do @(posedge clk); while (!cpuAck);
    @(negedge clk);
    cpuReq = 1'b0;
  endtask

  initial begin
    int word;
    logic write;
    dataWordT data;
    byteMaskT mask;
    reset = 1'b1;
    cpuReq = 1'b0;
    cpuWe = 1'b0;
    cpuAddr = '0;
    cpuWdata = '0;
    cpuMask = '0;
    flushReq = 1'b0;
    wbDatI = '0;
    wbAck = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      memModel[i] = 32'h9E3779B1 * i + 32'h0BAD0000;
      shadow[i] = memModel[i];
    end
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    checkFlag("cpuAck", cpuAck, 1'b0);
    checkFlag("wbCyc", wbCyc, 1'b0);
    checkFlag("flushDone", flushDone, 1'b0);
    @(negedge clk);

    // Cold misses first, then the same words hit
    for (int i = 0; i < 32; i++) begin
      cpuAccess(1'b0, (i % 16) * 3, '0, '0);
    end

    for (int i = 0; i < 8; i++) begin
      word = stimBits(8);
      data = dataWordT'(stimBits(32));
      mask = byteMaskT'(stimBits(4));
      cpuAccess(1'b1, word, data, mask);
      cpuAccess(1'b0, word, '0, '0);
    end

    // Three tags rotating through set 5
    for (int round = 0; round < 4; round++) begin
      for (int tag = 1; tag < 4; tag++) begin
        word = tag * 64 + 5 * 4 + round;
        data = dataWordT'(stimBits(32));
        mask = byteMaskT'(stimBits(4));
        cpuAccess(1'b1, word, data, mask);
        cpuAccess(1'b0, word, '0, '0);
      end
    end

    for (int i = 0; i < 200; i++) begin
      write = 1'(stimBits(1));
      word = stimBits(7);
      data = dataWordT'(stimBits(32));
      mask = byteMaskT'(stimBits(4));
      cpuAccess(write, word, data, mask);
    end

    flushReq = 1'b1;
    @(negedge clk);
    flushReq = 1'b0;
    do @(posedge clk); while (!flushDone);
    @(posedge clk);
    checkFlag("flushDone", flushDone, 1'b0);
    @(negedge clk);
    for (int i = 0; i < memWords; i++) begin
      checkData($sformatf("memModel[%0d]", i), memModel[i], shadow[i]);
    end

    // Refill from the flushed memory
    for (int i = 0; i < 8; i++) begin
      word = stimBits(7);
      cpuAccess(1'b0, word, '0, '0);
    end
    @(negedge clk);
    checkFlag("wbCyc", wbCyc, 1'b0);

    if (dut0.controller0.asserts0.failCount == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      reportFailure("a bus or CPU handshake assertion failed");
    end
  end

endmodule

// ==== build.f ====
hw/cacheGeomPkg.sv
hw/busPkg.sv
hw/cacheIfs.sv
hw/tagStore.sv
hw/dataStore.sv
hw/dcacheController.sv
hw/dcacheTop.sv
tests/dcacheAsserts.sv
tests/dcacheTb.sv
